//--- logic/pcie_dll_pkg.sv
// Data link layer definitions shared by the receive path.
// Covers the link status, stream sizing, LCRC constants and frame buffer depth.
`default_nettype none

package pcie_dll_pkg;

  typedef enum logic [1:0] {
    DL_INACTIVE = 2'd0,
    DL_INIT     = 2'd1,
    DL_ACTIVE   = 2'd2
  } link_status_e;

  localparam int DATA_W = 32;
  localparam int KEEP_W = DATA_W / 8;
  localparam int SEQ_W  = 12;

  // reflected form of 04C11DB7, register shifts toward bit 0
  localparam logic [31:0] LCRC_POLY = 32'hEDB8_8320;
  localparam logic [31:0] LCRC_SEED = 32'hFFFF_FFFF;

  localparam int MAX_PAYLOAD_BYTES = 256;
  // 4 header dwords plus the largest payload
  localparam int MAX_TLP_WORDS = 4 + MAX_PAYLOAD_BYTES / 4;
  localparam int RX_FRAMES = 2;
  localparam int FIFO_ADDR_W = $clog2(RX_FRAMES * MAX_TLP_WORDS);

endpackage

`default_nettype wire

//--- logic/pcie_tlp_pkg.sv
// TLP format and type codes and the first header dword layout.
// Used to classify received TLPs for flow-control credit accounting.
`default_nettype none

package pcie_tlp_pkg;

  // fmt[2:0] in bits 7:5, type[4:0] in bits 4:0
  typedef enum logic [7:0] {
    MRD32   = 8'h00,
    MRDLK32 = 8'h01,
    IORD    = 8'h02,
    CFGRD0  = 8'h04,
    CFGRD1  = 8'h05,
    CPL     = 8'h0A,
    CPLLK   = 8'h0B,
    MRD64   = 8'h20,
    MRDLK64 = 8'h21,
    MSG     = 8'h30,
    MWR32   = 8'h40,
    IOWR    = 8'h42,
    CFGWR0  = 8'h44,
    CFGWR1  = 8'h45,
    CPLD    = 8'h4A,
    CPLDLK  = 8'h4B,
    MWR64   = 8'h60,
    MSGD    = 8'h70
  } tlp_fmt_type_e;

  // header byte 0 sits in the low byte of the realigned beat
  typedef struct packed {
    logic [7:0]    len_lo;
    logic          td;
    logic          ep;
    logic [1:0]    attr;
    logic [1:0]    at;
    logic [1:0]    len_hi;
    logic          t9;
    logic [2:0]    tc;
    logic          t8;
    logic          attr2;
    logic          ln;
    logic          th;
    tlp_fmt_type_e fmt_type;
  } tlp_dw0_fields_t;

  typedef union packed {
    logic [31:0]     raw;
    tlp_dw0_fields_t f;
  } tlp_dw0_u;

  typedef enum logic [1:0] {
    CC_NONE      = 2'd0,
    CC_POSTED    = 2'd1,
    CC_NONPOSTED = 2'd2,
    CC_CPL       = 2'd3
  } credit_class_e;

  localparam int HDR_CREDIT_W  = 8;
  localparam int DATA_CREDIT_W = 12;

endpackage

`default_nettype wire

//--- logic/lcrc32_calc.sv
// Combinational LCRC step for one stream beat.
// Folds nbytes_i+1 bytes, lowest byte first, into the running reflected CRC-32.
`timescale 1ns/10ps
`default_nettype none

module lcrc32_calc (
  input  logic [pcie_dll_pkg::DATA_W-1:0] data_i,
  input  logic [31:0]                     crc_i,
  input  logic [1:0]                      nbytes_i,
  output logic [31:0]                     crc_o
);
  import pcie_dll_pkg::*;

  logic [31:0] crc;

  always_comb begin
    crc = crc_i;
    for (int b = 0; b < KEEP_W; b++) begin
      if (b <= int'(nbytes_i)) begin
        // bit-serial, lsb of each byte enters first
        for (int i = 0; i < 8; i++) begin
          crc = (crc >> 1) ^ (LCRC_POLY & {32{crc[0] ^ data_i[8*b+i]}});
        end
      end
    end
    crc_o = crc;
  end

endmodule

`default_nettype wire

//--- logic/tlp_credit_counter.sv
// Consumed flow-control credit counters for the six credit types.
// Header is captured on hdr_valid_i, counts move one cycle after tlp_good_i.
`timescale 1ns/10ps
`default_nettype none

module tlp_credit_counter (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  pcie_tlp_pkg::tlp_dw0_u                  hdr_dw0_i,
  input  logic                                    hdr_valid_i,
  input  logic                                    tlp_good_i,
  output logic [pcie_tlp_pkg::HDR_CREDIT_W-1:0]  ph_o,
  output logic [pcie_tlp_pkg::HDR_CREDIT_W-1:0]  nph_o,
  output logic [pcie_tlp_pkg::HDR_CREDIT_W-1:0]  cplh_o,
  output logic [pcie_tlp_pkg::DATA_CREDIT_W-1:0] pd_o,
  output logic [pcie_tlp_pkg::DATA_CREDIT_W-1:0] npd_o,
  output logic [pcie_tlp_pkg::DATA_CREDIT_W-1:0] cpld_o
);
  import pcie_tlp_pkg::*;

  tlp_fmt_type_e            ft;
  credit_class_e            cls_d;
  credit_class_e            cls_q;
  logic                     has_data_d;
  logic                     has_data_q;
  logic                     hdr_seen_q;
  logic [9:0]               len;
  logic [10:0]              len_dw;
  logic [DATA_CREDIT_W-1:0] dcred_d;
  logic [DATA_CREDIT_W-1:0] dcred_q;

  // length 0 encodes 1024 dwords, one data credit per 4 dwords
  assign len     = {hdr_dw0_i.f.len_hi, hdr_dw0_i.f.len_lo};
  assign len_dw  = {~|len, len};
  assign dcred_d = DATA_CREDIT_W'((len_dw + 11'd3) >> 2);

  always_comb begin
    ft = hdr_dw0_i.f.fmt_type;
    // messages keep their routing code in the low type bits
    if (ft[4:3] == 2'b10) begin
      ft = tlp_fmt_type_e'({ft[7:3], 3'b000});
    end
    cls_d      = CC_NONE;
    has_data_d = 1'b0;
    case (ft)
      MWR32, MWR64, MSGD: begin
        cls_d      = CC_POSTED;
        has_data_d = 1'b1;
      end
      MSG: cls_d = CC_POSTED;
      MRD32, MRD64, MRDLK32, MRDLK64, IORD, CFGRD0, CFGRD1: cls_d = CC_NONPOSTED;
      IOWR, CFGWR0, CFGWR1: begin
        cls_d      = CC_NONPOSTED;
        has_data_d = 1'b1;
      end
      CPL, CPLLK: cls_d = CC_CPL;
      CPLD, CPLDLK: begin
        cls_d      = CC_CPL;
        has_data_d = 1'b1;
      end
      default: cls_d = CC_NONE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (hdr_valid_i) begin
      dcred_q <= dcred_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cls_q      <= CC_NONE;
      has_data_q <= 1'b0;
      hdr_seen_q <= 1'b0;
      ph_o       <= '0;
      nph_o      <= '0;
      cplh_o     <= '0;
      pd_o       <= '0;
      npd_o      <= '0;
      cpld_o     <= '0;
    end else begin
      if (hdr_valid_i) begin
        cls_q      <= cls_d;
        has_data_q <= has_data_d;
        hdr_seen_q <= 1'b1;
      end else if (tlp_good_i) begin
        hdr_seen_q <= 1'b0;
      end
      if (tlp_good_i) begin
        case (cls_q)
          CC_POSTED: begin
            ph_o <= ph_o + 1'b1;
            if (has_data_q) begin
              pd_o <= pd_o + dcred_q;
            end
          end
          CC_NONPOSTED: begin
            nph_o <= nph_o + 1'b1;
            if (has_data_q) begin
              npd_o <= npd_o + dcred_q;
            end
          end
          CC_CPL: begin
            cplh_o <= cplh_o + 1'b1;
            if (has_data_q) begin
              cpld_o <= cpld_o + dcred_q;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // a good verdict needs the header pulse of the same packet
  a_good_has_hdr : assert property (@(posedge clk_i) disable iff (rst_i)
    tlp_good_i |-> hdr_seen_q);

endmodule

`default_nettype wire

//--- logic/tlp_frame_fifo.sv
// Frame buffer between the link layer and the transaction layer.
// Writes stay hidden until commit_i; drop_i rewinds the write pointer to the
// last committed frame. wr_ready_o means a maximum-size TLP still fits.
`timescale 1ns/10ps
`default_nettype none

module tlp_frame_fifo (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic [pcie_dll_pkg::DATA_W-1:0]   wr_data_i,
  input  logic [pcie_dll_pkg::KEEP_W-1:0]   wr_keep_i,
  input  logic                              wr_valid_i,
  input  logic                              wr_last_i,
  input  logic                              commit_i,
  input  logic                              drop_i,
  output logic                              wr_ready_o,
  output logic [pcie_dll_pkg::DATA_W-1:0]   m_tdata_o,
  output logic [pcie_dll_pkg::KEEP_W-1:0]   m_tkeep_o,
  output logic                              m_tvalid_o,
  output logic                              m_tlast_o,
  input  logic                              m_tready_i
);
  import pcie_dll_pkg::*;

  // entry holds {last, keep, data}
  logic [DATA_W+KEEP_W:0] mem [2**FIFO_ADDR_W];
  logic [FIFO_ADDR_W:0]   wr_ptr_q;
  logic [FIFO_ADDR_W:0]   wr_ptr_nxt;
  logic [FIFO_ADDR_W:0]   cmt_ptr_q;
  logic [FIFO_ADDR_W:0]   rd_ptr_q;
  logic [FIFO_ADDR_W:0]   used;
  logic                   full;
  logic                   rd_en;
  logic                   wr_ready_q;

  assign wr_ptr_nxt = wr_ptr_q + {{FIFO_ADDR_W{1'b0}}, wr_valid_i};
  assign used       = wr_ptr_q - rd_ptr_q;
  assign full       = used[FIFO_ADDR_W];

  // only committed entries are visible to the reader
  assign m_tvalid_o = (rd_ptr_q != cmt_ptr_q);
  assign rd_en      = m_tvalid_o && m_tready_i;
  assign {m_tlast_o, m_tkeep_o, m_tdata_o} = mem[rd_ptr_q[FIFO_ADDR_W-1:0]];
  assign wr_ready_o = wr_ready_q;

  always_ff @(posedge clk_i) begin
    if (wr_valid_i) begin
      mem[wr_ptr_q[FIFO_ADDR_W-1:0]] <= {wr_last_i, wr_keep_i, wr_data_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q   <= '0;
      cmt_ptr_q  <= '0;
      rd_ptr_q   <= '0;
      wr_ready_q <= 1'b0;
    end else begin
      // a write in the drop cycle is discarded with the rest of the frame
      if (drop_i) begin
        wr_ptr_q <= cmt_ptr_q;
      end else begin
        wr_ptr_q <= wr_ptr_nxt;
      end
      if (commit_i) begin
        cmt_ptr_q <= wr_ptr_nxt;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      wr_ready_q <= (int'(used) + MAX_TLP_WORDS <= 2 ** FIFO_ADDR_W);
    end
  end

  a_no_write_full : assert property (@(posedge clk_i) disable iff (rst_i)
    wr_valid_i |-> !full);

  a_verdict_excl : assert property (@(posedge clk_i) disable iff (rst_i)
    commit_i |-> !drop_i);

endmodule

`default_nettype wire

//--- logic/dll_rx_framer.sv
// Receive framer of the data link layer.
// Strips the sequence number, realigns the TLP by 16 bits, checks LCRC and
// sequence, writes the TLP to the frame buffer and requests a flow-control update.
`timescale 1ns/10ps
`default_nettype none

module dll_rx_framer (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  pcie_dll_pkg::link_status_e        link_status_i,
  input  logic [pcie_dll_pkg::DATA_W-1:0]   s_tdata_i,
  input  logic [pcie_dll_pkg::KEEP_W-1:0]   s_tkeep_i,
  input  logic                              s_tvalid_i,
  input  logic                              s_tlast_i,
  output logic                              s_tready_o,
  output logic [pcie_dll_pkg::DATA_W-1:0]   crc_beat_o,
  output logic [31:0]                       crc_run_o,
  output logic [1:0]                        crc_nbytes_o,
  input  logic [31:0]                       crc_next_i,
  output logic [pcie_dll_pkg::DATA_W-1:0]   wr_data_o,
  output logic [pcie_dll_pkg::KEEP_W-1:0]   wr_keep_o,
  output logic                              wr_valid_o,
  output logic                              wr_last_o,
  output logic                              commit_o,
  output logic                              drop_o,
  input  logic                              wr_ready_i,
  output pcie_tlp_pkg::tlp_dw0_u            hdr_dw0_o,
  output logic                              hdr_valid_o,
  output logic                              tlp_good_o,
  output logic                              fc_start_o,
  input  logic                              fc_start_ack_i,
  output logic [pcie_dll_pkg::SEQ_W-1:0]    next_rcv_seq_o,
  output logic                              tlp_nullified_o
);
  import pcie_dll_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HEADER,
    ST_STREAM,
    ST_TAIL,
    ST_VERDICT,
    ST_ACK
  } rx_state_e;

  rx_state_e          state_q;
  logic               link_ok;
  logic               beat_acc;
  logic               bad_keep;
  logic               room;
  logic               stream_wr;
  logic               pkt_good;
  logic [DATA_W-1:0]  prev_q;
  logic [DATA_W-1:0]  pend_q;
  logic [DATA_W-1:0]  realigned;
  logic [31:0]        crc_q;
  logic [31:0]        rx_lcrc_q;
  logic [SEQ_W-1:0]   rx_seq_q;
  logic [SEQ_W-1:0]   exp_seq_q;
  logic [7:0]         dw_cnt_q;
  logic               bad_q;
  logic               fc_start_q;
  logic               nullified_q;

  assign link_ok = (link_status_i == DL_ACTIVE);

  // buffer space for a whole TLP is checked only at packet start
  always_comb begin
    case (state_q)
      ST_IDLE:                       s_tready_o = link_ok && wr_ready_i;
      ST_HEADER, ST_STREAM, ST_TAIL: s_tready_o = link_ok;
      default:                       s_tready_o = 1'b0;
    endcase
  end

  assign beat_acc  = s_tvalid_i && s_tready_o;
  assign bad_keep  = !s_tlast_i && (s_tkeep_i != '1);
  assign room      = (dw_cnt_q < 8'(MAX_TLP_WORDS));
  assign realigned = {s_tdata_i[15:0], prev_q[31:16]};

  // crc runs one beat behind, the last beat only adds 2 bytes of the one before
  assign crc_beat_o   = prev_q;
  assign crc_run_o    = crc_q;
  assign crc_nbytes_o = s_tlast_i ? 2'd1 : 2'd3;

  // received LCRC is the inverted register, lowest byte first on the link
  assign pkt_good = !bad_q && (~crc_q == rx_lcrc_q) && (rx_seq_q == exp_seq_q);

  // each dword is written once the following beat proves it is not the last
  assign stream_wr  = beat_acc && (state_q == ST_STREAM) && !s_tlast_i && room;
  assign wr_data_o  = pend_q;
  assign wr_keep_o  = '1;
  assign wr_valid_o = stream_wr || (state_q == ST_VERDICT);
  assign wr_last_o  = (state_q == ST_VERDICT);
  assign commit_o   = (state_q == ST_VERDICT) && pkt_good;
  assign drop_o     = (state_q == ST_VERDICT) && !pkt_good;
  assign tlp_good_o = commit_o;

  assign hdr_dw0_o.raw = realigned;
  assign hdr_valid_o   = beat_acc && (state_q == ST_HEADER) && !s_tlast_i;

  assign fc_start_o      = fc_start_q;
  assign next_rcv_seq_o  = exp_seq_q;
  assign tlp_nullified_o = nullified_q;

  always_ff @(posedge clk_i) begin
    if (beat_acc) begin
      prev_q <= s_tdata_i;
      if (state_q == ST_IDLE) begin
        // seq sits in the low 12 bits of the first two bytes, msb byte first
        rx_seq_q <= SEQ_W'({s_tdata_i[7:0], s_tdata_i[15:8]});
        crc_q    <= LCRC_SEED;
      end else if (state_q != ST_TAIL) begin
        crc_q <= crc_next_i;
        if (s_tlast_i) begin
          rx_lcrc_q <= realigned;
        end else if (room) begin
          pend_q <= realigned;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      dw_cnt_q    <= '0;
      bad_q       <= 1'b0;
      fc_start_q  <= 1'b0;
      nullified_q <= 1'b0;
      exp_seq_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (beat_acc) begin
            nullified_q <= 1'b0;
            dw_cnt_q    <= '0;
            bad_q       <= bad_keep || s_tlast_i;
            if (s_tlast_i) begin
              state_q <= ST_VERDICT;
            end else if (bad_keep) begin
              state_q <= ST_TAIL;
            end else begin
              state_q <= ST_HEADER;
            end
          end
        end
        ST_HEADER: begin
          if (beat_acc) begin
            dw_cnt_q <= 8'd1;
            if (s_tlast_i) begin
              // no complete dword before the LCRC
              bad_q   <= 1'b1;
              state_q <= ST_VERDICT;
            end else if (bad_keep) begin
              bad_q   <= 1'b1;
              state_q <= ST_TAIL;
            end else begin
              state_q <= ST_STREAM;
            end
          end
        end
        ST_STREAM: begin
          if (beat_acc) begin
            if (s_tlast_i) begin
              bad_q   <= bad_q || (s_tkeep_i != 4'b0011);
              state_q <= ST_VERDICT;
            end else begin
              if (room) begin
                dw_cnt_q <= dw_cnt_q + 1'b1;
              end
              if (bad_keep || !room) begin
                bad_q   <= 1'b1;
                state_q <= ST_TAIL;
              end
            end
          end
        end
        // discard the rest of a malformed packet
        ST_TAIL: begin
          if (beat_acc && s_tlast_i) begin
            state_q <= ST_VERDICT;
          end
        end
        ST_VERDICT: begin
          fc_start_q  <= 1'b1;
          nullified_q <= !pkt_good;
          if (pkt_good) begin
            exp_seq_q <= exp_seq_q + 1'b1;
          end
          state_q <= ST_ACK;
        end
        ST_ACK: begin
          if (fc_start_ack_i) begin
            fc_start_q <= 1'b0;
            state_q    <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  a_ready_needs_link : assert property (@(posedge clk_i) disable iff (rst_i)
    s_tready_o |-> link_status_i == DL_ACTIVE);

endmodule

`default_nettype wire

//--- logic/dll_rx_top.sv
// Receive half of the PCIe data link layer.
// Connects the framer, LCRC step, credit counter and frame buffer.
`timescale 1ns/10ps
`default_nettype none

module dll_rx_top (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  pcie_dll_pkg::link_status_e              link_status_i,
  input  logic [pcie_dll_pkg::DATA_W-1:0]         s_tdata_i,
  input  logic [pcie_dll_pkg::KEEP_W-1:0]         s_tkeep_i,
  input  logic                                    s_tvalid_i,
  input  logic                                    s_tlast_i,
  output logic                                    s_tready_o,
  output logic                                    fc_start_o,
  input  logic                                    fc_start_ack_i,
  output logic [pcie_dll_pkg::DATA_W-1:0]         m_tdata_o,
  output logic [pcie_dll_pkg::KEEP_W-1:0]         m_tkeep_o,
  output logic                                    m_tvalid_o,
  output logic                                    m_tlast_o,
  input  logic                                    m_tready_i,
  output logic [pcie_dll_pkg::SEQ_W-1:0]          next_rcv_seq_o,
  output logic                                    tlp_nullified_o,
  output logic [pcie_tlp_pkg::HDR_CREDIT_W-1:0]  ph_o,
  output logic [pcie_tlp_pkg::DATA_CREDIT_W-1:0] pd_o,
  output logic [pcie_tlp_pkg::HDR_CREDIT_W-1:0]  nph_o,
  output logic [pcie_tlp_pkg::DATA_CREDIT_W-1:0] npd_o,
  output logic [pcie_tlp_pkg::HDR_CREDIT_W-1:0]  cplh_o,
  output logic [pcie_tlp_pkg::DATA_CREDIT_W-1:0] cpld_o
);
  import pcie_dll_pkg::*;
  import pcie_tlp_pkg::*;

  logic [DATA_W-1:0] crc_beat;
  logic [31:0]       crc_run;
  logic [1:0]        crc_nbytes;
  logic [31:0]       crc_next;
  logic [DATA_W-1:0] wr_data;
  logic [KEEP_W-1:0] wr_keep;
  logic              wr_valid;
  logic              wr_last;
  logic              commit;
  logic              drop;
  logic              wr_ready;
  tlp_dw0_u          hdr_dw0;
  logic              hdr_valid;
  logic              tlp_good;

  dll_rx_framer framer_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .link_status_i   (link_status_i),
    .s_tdata_i       (s_tdata_i),
    .s_tkeep_i       (s_tkeep_i),
    .s_tvalid_i      (s_tvalid_i),
    .s_tlast_i       (s_tlast_i),
    .s_tready_o      (s_tready_o),
    .crc_beat_o      (crc_beat),
    .crc_run_o       (crc_run),
    .crc_nbytes_o    (crc_nbytes),
    .crc_next_i      (crc_next),
    .wr_data_o       (wr_data),
    .wr_keep_o       (wr_keep),
    .wr_valid_o      (wr_valid),
    .wr_last_o       (wr_last),
    .commit_o        (commit),
    .drop_o          (drop),
    .wr_ready_i      (wr_ready),
    .hdr_dw0_o       (hdr_dw0),
    .hdr_valid_o     (hdr_valid),
    .tlp_good_o      (tlp_good),
    .fc_start_o      (fc_start_o),
    .fc_start_ack_i  (fc_start_ack_i),
    .next_rcv_seq_o  (next_rcv_seq_o),
    .tlp_nullified_o (tlp_nullified_o)
  );

  lcrc32_calc lcrc_i (
    .data_i   (crc_beat),
    .crc_i    (crc_run),
    .nbytes_i (crc_nbytes),
    .crc_o    (crc_next)
  );

  tlp_credit_counter credits_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .hdr_dw0_i   (hdr_dw0),
    .hdr_valid_i (hdr_valid),
    .tlp_good_i  (tlp_good),
    .ph_o        (ph_o),
    .nph_o       (nph_o),
    .cplh_o      (cplh_o),
    .pd_o        (pd_o),
    .npd_o       (npd_o),
    .cpld_o      (cpld_o)
  );

  tlp_frame_fifo fifo_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_data_i  (wr_data),
    .wr_keep_i  (wr_keep),
    .wr_valid_i (wr_valid),
    .wr_last_i  (wr_last),
    .commit_i   (commit),
    .drop_i     (drop),
    .wr_ready_o (wr_ready),
    .m_tdata_o  (m_tdata_o),
    .m_tkeep_o  (m_tkeep_o),
    .m_tvalid_o (m_tvalid_o),
    .m_tlast_o  (m_tlast_o),
    .m_tready_i (m_tready_i)
  );

endmodule

`default_nettype wire

//--- verif/dll_rx_tb_checks.svh
// Compare tasks for the receive link layer testbench.
// Included inside the testbench module; each check stops the run at the first mismatch.
`ifndef DLL_RX_TB_CHECKS_SVH
`define DLL_RX_TB_CHECKS_SVH
`default_nettype none

task automatic stop_run();
  $display("Simulation failed");
  $fatal(1, "run stopped on error");
endtask

task automatic check_beat(input logic [pcie_dll_pkg::DATA_W-1:0] got_d,
                          input logic [pcie_dll_pkg::DATA_W-1:0] exp_d,
                          input logic [pcie_dll_pkg::KEEP_W-1:0] got_k,
                          input logic got_l,
                          input logic exp_l);
  if (got_d !== exp_d) begin
    $display("ERR %0t m_tdata_o got %h expected %h", $time, got_d, exp_d);
    stop_run();
  end
  if (got_k !== '1) begin
    $display("ERR %0t m_tkeep_o got %h expected %h", $time, got_k, 4'hf);
    stop_run();
  end
  if (got_l !== exp_l) begin
    $display("ERR %0t m_tlast_o got %b expected %b", $time, got_l, exp_l);
    stop_run();
  end
endtask

task automatic check_hdr_credit(input string name,
                                input logic [pcie_tlp_pkg::HDR_CREDIT_W-1:0] got,
                                input logic [pcie_tlp_pkg::HDR_CREDIT_W-1:0] exp);
  if (got !== exp) begin
    $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
    stop_run();
  end
endtask

task automatic check_data_credit(input string name,
                                 input logic [pcie_tlp_pkg::DATA_CREDIT_W-1:0] got,
                                 input logic [pcie_tlp_pkg::DATA_CREDIT_W-1:0] exp);
  if (got !== exp) begin
    $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
    stop_run();
  end
endtask

task automatic check_seq(input logic [pcie_dll_pkg::SEQ_W-1:0] got,
                         input logic [pcie_dll_pkg::SEQ_W-1:0] exp);
  if (got !== exp) begin
    $display("ERR %0t next_rcv_seq_o got %h expected %h", $time, got, exp);
    stop_run();
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    stop_run();
  end
endtask

`default_nettype wire
`endif

//--- verif/dll_rx_tb.sv
// Testbench for the receive link layer top level.
// Reads packets from the data file, frames them with seq and LCRC, and checks
// the output stream, verdict, credit counts and sequence number.
`timescale 1ns/10ps
`default_nettype none

module dll_rx_tb;
  import pcie_dll_pkg::*;
  import pcie_tlp_pkg::*;

  typedef struct {
    logic [SEQ_W-1:0] seq;
    int               ndw;
    logic [3:0]       keep;
    int               flip;
    int               good;
    int               d[6];
    logic [4:0][31:0] dw;
  } rec_t;

  logic clk_i;
  logic rst_i;
  link_status_e link_status_i;
  logic [DATA_W-1:0] s_tdata_i;
  logic [KEEP_W-1:0] s_tkeep_i;
  logic s_tvalid_i;
  logic s_tlast_i;
  logic s_tready_o;
  logic fc_start_o;
  logic fc_start_ack_i;
  logic [DATA_W-1:0] m_tdata_o;
  logic [KEEP_W-1:0] m_tkeep_o;
  logic m_tvalid_o;
  logic m_tlast_o;
  logic m_tready_i;
  logic [SEQ_W-1:0] next_rcv_seq_o;
  logic tlp_nullified_o;
  logic [HDR_CREDIT_W-1:0] ph_o, nph_o, cplh_o;
  logic [DATA_CREDIT_W-1:0] pd_o, npd_o, cpld_o;

  integer seed = 32'h91a8_25ee;
  logic hold_out;
  logic loaded;
  rec_t recs[$];
  logic [31:0] exp_data[$];
  logic exp_last[$];

  `include "dll_rx_tb_checks.svh"

  dll_rx_top dll_rx_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // reflected CRC-32, data lsb first
  function automatic logic [31:0] crc_add_byte(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ b[i]) c = (c >> 1) ^ 32'hEDB8_8320;
      else c = c >> 1;
    end
    return c;
  endfunction

  task automatic send_beat(input logic [31:0] d, input logic [3:0] k, input logic l);
    logic accepted;
    s_tdata_i  = d;
    s_tkeep_i  = k;
    s_tlast_i  = l;
    s_tvalid_i = 1'b1;
    accepted   = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = s_tready_o;
      @(posedge clk_i);
      #2;
    end
  endtask

  // seq in 2 bytes, TLP shifted by 16 bits, LCRC low byte first
  task automatic send_packet(input rec_t r);
    logic [31:0] crc;
    logic [31:0] lcrc;
    logic [31:0] beats[$];
    crc = 32'hFFFF_FFFF;
    crc = crc_add_byte(crc, {4'h0, r.seq[11:8]});
    crc = crc_add_byte(crc, r.seq[7:0]);
    for (int k = 0; k < r.ndw; k++) begin
      for (int j = 0; j < 4; j++) crc = crc_add_byte(crc, r.dw[k][8*j +: 8]);
    end
    lcrc = ~crc;
    if (r.flip != 0) lcrc[5] = ~lcrc[5];
    beats.push_back({r.dw[0][15:0], r.seq[7:0], 4'h0, r.seq[11:8]});
    for (int k = 1; k < r.ndw; k++) beats.push_back({r.dw[k][15:0], r.dw[k-1][31:16]});
    beats.push_back({lcrc[15:0], r.dw[r.ndw-1][31:16]});
    beats.push_back({16'h0000, lcrc[31:16]});
    for (int i = 0; i < beats.size(); i++) begin
      if (i == beats.size() - 1) send_beat(beats[i], r.keep, 1'b1);
      else send_beat(beats[i], 4'hf, 1'b0);
    end
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
  endtask

  task automatic link_down_check(input int n);
    link_status_i = DL_INIT;
    repeat (n) begin
      @(negedge clk_i);
      check_flag("s_tready_o", s_tready_o, 1'b0);
    end
    @(posedge clk_i);
    #2;
    link_status_i = DL_ACTIVE;
  endtask

  task automatic load_records();
    int fd;
    int rc;
    string line;
    rec_t r;
    fd = $fopen("verif/dll_rx_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file");
      stop_run();
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc == 0 || line.len() < 2 || line.getc(0) == 8'h23) continue;
      rc = $sscanf(line, "%h %d %h %d %d %d %d %d %d %d %d %h %h %h %h %h",
                   r.seq, r.ndw, r.keep, r.flip, r.good, r.d[0], r.d[1], r.d[2],
                   r.d[3], r.d[4], r.d[5], r.dw[0], r.dw[1], r.dw[2], r.dw[3], r.dw[4]);
      if (rc != 16) begin
        $display("malformed line in the test data file");
        stop_run();
      end
      recs.push_back(r);
    end
    $fclose(fd);
  endtask

  // output stall source
  initial begin
    m_tready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      m_tready_i = !hold_out && (($random(seed) & 3) != 0);
    end
  end

  // output monitor compares each handshake with the expected dwords
  initial begin
    forever begin
      @(negedge clk_i);
      if (!rst_i && m_tvalid_o && m_tready_i) begin
        if (exp_data.size() == 0) begin
          $display("output beat arrived with no good frame pending");
          stop_run();
        end
        check_beat(m_tdata_o, exp_data.pop_front(), m_tkeep_o, m_tlast_o, exp_last.pop_front());
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (recs.size() * 2000 + 100) @(posedge clk_i);
    $display("watchdog expired before all packets were checked");
    stop_run();
  end

  initial begin
    logic [HDR_CREDIT_W-1:0]  ph_e, nph_e, cplh_e;
    logic [DATA_CREDIT_W-1:0] pd_e, npd_e, cpld_e;
    logic [SEQ_W-1:0]         seq_e;
    rec_t r;
    rst_i = 1'b1;
    link_status_i = DL_INACTIVE;
    s_tdata_i = '0;
    s_tkeep_i = '0;
    s_tvalid_i = 1'b0;
    s_tlast_i = 1'b0;
    fc_start_ack_i = 1'b0;
    hold_out = 1'b1;
    loaded = 1'b0;
    {ph_e, nph_e, cplh_e, pd_e, npd_e, cpld_e} = '0;
    seq_e = '0;
    load_records();
    loaded = 1'b1;
    repeat (16) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    link_down_check(4);
    // idle receiver right after reset
    check_flag("m_tvalid_o", m_tvalid_o, 1'b0);
    check_flag("fc_start_o", fc_start_o, 1'b0);
    check_flag("tlp_nullified_o", tlp_nullified_o, 1'b0);
    check_seq(next_rcv_seq_o, seq_e);
    for (int i = 0; i < recs.size(); i++) begin
      r = recs[i];
      // first two frames wait in the buffer, then drain under random stalls
      if (i == 2) begin
        check_flag("m_tvalid_o", m_tvalid_o, 1'b1);
        hold_out = 1'b0;
      end
      if (i == 5) link_down_check(4);
      if (r.good != 0) begin
        seq_e = seq_e + 1'b1;
        for (int k = 0; k < r.ndw; k++) begin
          exp_data.push_back(r.dw[k]);
          exp_last.push_back(k == r.ndw - 1);
        end
      end
      // credit deltas of a nullified packet are zero in the file
      ph_e   = ph_e + HDR_CREDIT_W'(r.d[0]);
      pd_e   = pd_e + DATA_CREDIT_W'(r.d[1]);
      nph_e  = nph_e + HDR_CREDIT_W'(r.d[2]);
      npd_e  = npd_e + DATA_CREDIT_W'(r.d[3]);
      cplh_e = cplh_e + HDR_CREDIT_W'(r.d[4]);
      cpld_e = cpld_e + DATA_CREDIT_W'(r.d[5]);
      send_packet(r);
      do @(negedge clk_i); while (!fc_start_o);
      repeat (3) begin
        check_flag("fc_start_o", fc_start_o, 1'b1);
        check_flag("s_tready_o", s_tready_o, 1'b0);
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #2;
      fc_start_ack_i = 1'b1;
      @(posedge clk_i);
      #2;
      fc_start_ack_i = 1'b0;
      @(negedge clk_i);
      check_flag("fc_start_o", fc_start_o, 1'b0);
      check_flag("tlp_nullified_o", tlp_nullified_o, r.good == 0);
      check_seq(next_rcv_seq_o, seq_e);
      check_hdr_credit("ph_o", ph_o, ph_e);
      check_data_credit("pd_o", pd_o, pd_e);
      check_hdr_credit("nph_o", nph_o, nph_e);
      check_data_credit("npd_o", npd_o, npd_e);
      check_hdr_credit("cplh_o", cplh_o, cplh_e);
      check_data_credit("cpld_o", cpld_o, cpld_e);
      @(posedge clk_i);
      #2;
    end
    hold_out = 1'b0;
    while (exp_data.size() != 0) @(negedge clk_i);
    repeat (4) @(posedge clk_i);
    if (recs.size() != 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("no packets were read from the test data file");
      stop_run();
    end
  end

endmodule

`default_nettype wire

//--- verif/dll_rx_testdata.txt
# seq ndw lastkeep flip good | dph dpd dnph dnpd dcplh dcpld | tlp dwords 0..4 (hex)
# flip inverts one LCRC bit; lastkeep other than 3 nullifies the packet
000 5 3 0 1 1 1 0 0 0 0 02000040 0000000f 10002000 a5a50001 5a5a0002
001 3 3 0 1 0 0 1 0 0 0 04000000 000000ff 10003000 00000000 00000000
002 4 3 0 1 0 0 1 1 0 0 01000044 01000f01 00010000 deadbeef 00000000
003 4 3 0 1 0 0 0 0 1 1 0100004a 00000004 00000000 cafef00d 00000000
004 4 3 0 1 0 0 0 0 0 0 0100001f 00000000 00000000 11111111 00000000
005 4 3 1 0 0 0 0 0 0 0 01000040 0000000f 10002000 0bad0bad 00000000
007 4 3 0 0 0 0 0 0 0 0 01000040 0000000f 10002000 0bad0bad 00000000
005 4 7 0 0 0 0 0 0 0 0 01000040 0000000f 10002000 0bad0bad 00000000
005 5 3 0 1 1 1 0 0 0 0 01000060 00000000 00000001 00000000 12345678
006 4 3 0 1 1 0 0 0 0 0 00000034 00000000 00000000 00000000 00000000
007 4 3 0 1 1 256 0 0 0 0 00000040 0000000f 10004000 00000000 00000000
008 4 3 0 1 0 0 0 0 1 2 0600004a 00000004 00000000 77665544 00000000

//--- filelist.f
+incdir+verif
logic/pcie_dll_pkg.sv
logic/pcie_tlp_pkg.sv
logic/lcrc32_calc.sv
logic/tlp_credit_counter.sv
logic/tlp_frame_fifo.sv
logic/dll_rx_framer.sv
logic/dll_rx_top.sv
verif/dll_rx_tb.sv

//--- Makefile
# Verilator build for the PCIe link layer receive testbench

TOOL     ?= verilator
TOP      ?= dll_rx_tb
FILELIST ?= filelist.f
FLAGS    ?= --timing --assert -j 0
OBJDIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o V$(TOP)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
